/* design/eeprom_defines.svh */
`ifndef EEPROM_DEFINES_SVH
`define EEPROM_DEFINES_SVH

// apb register byte offsets
`define EE_REG_ADDR   4'h0
`define EE_REG_WDATA  4'h4
`define EE_REG_CMD    4'h8
`define EE_REG_STATUS 4'hC

`define EE_RDATA_OFS  8        // read byte sits in status 15:8

// clocks per quarter of an scl period
`define EE_SCL_QTR    2

`define EE_DEV_CODE   4'b1010  // 24cxx device code
`define EE_MEM_BYTES  2048

`endif

/* design/eeprom_types_pkg.sv */
package eeprom_types_pkg;

    // 2k byte array, bits 10:8 go out in the control byte
    typedef logic [10:0] ee_addr_t;

    typedef logic [7:0]  ee_byte_t;

    // register offsets inside the block
    typedef logic [3:0]  apb_addr_t;

    typedef logic [31:0] apb_word_t;

endpackage

/* design/eeprom_bus_pkg.sv */
package eeprom_bus_pkg;
    import eeprom_types_pkg::*;

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_word_t pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_word_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic     valid;    // single cycle
        logic     is_read;
        ee_addr_t addr;
        ee_byte_t wdata;
    } ee_cmd_t;

    typedef struct packed {
        logic     done;
        logic     nack;
        ee_byte_t rdata;
    } ee_rsp_t;

    typedef enum logic [2:0] {
        OP_START,
        OP_RESTART,
        OP_WRITE,
        OP_READ,
        OP_STOP
    } bit_op_e;

    typedef struct packed {
        logic     valid;    // held until done
        bit_op_e  op;
        ee_byte_t tx;
    } bit_req_t;

    typedef struct packed {
        logic     done;
        logic     ack_ok;
        ee_byte_t rx;
    } bit_rsp_t;

endpackage

/* design/eeprom_apb_regs.sv */
`timescale 1ns/1ns
`include "eeprom_defines.svh"

module eeprom_apb_regs
    import eeprom_types_pkg::*;
    import eeprom_bus_pkg::*;
(
    input  logic     CLK,
    input  logic     RESET,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp,
    output ee_cmd_t  cmd,
    input  ee_rsp_t  rsp
);

    logic      access;
    logic      wr_acc;
    logic      hit;
    logic      cmd_wr;
    logic      cmd_ok;
    logic      busy_q;
    logic      done_q;
    logic      nack_q;
    logic      cmd_valid_q;
    logic      cmd_read_q;
    ee_addr_t  addr_q;
    ee_byte_t  wdata_q;
    ee_byte_t  rdata_q;
    apb_word_t status;

    assign access = apb_req.psel && apb_req.penable;
    assign wr_acc = access && apb_req.pwrite;
    assign cmd_wr = wr_acc && (apb_req.paddr == `EE_REG_CMD);

    // needs a start bit and an idle sequencer
    assign cmd_ok = cmd_wr && !busy_q && (apb_req.pwdata[1:0] != 2'b00);

    always_comb
    begin
        status = '0;
        status[0] = busy_q;
        status[1] = done_q;
        status[2] = nack_q;
        status[`EE_RDATA_OFS +: 8] = rdata_q;
    end

    always_comb
    begin
        hit = 1'b1;
        apb_rsp.prdata = '0;
        case (apb_req.paddr)
            `EE_REG_ADDR:   apb_rsp.prdata = apb_word_t'(addr_q);
            `EE_REG_WDATA:  apb_rsp.prdata = apb_word_t'(wdata_q);
            `EE_REG_CMD:    apb_rsp.prdata = '0;   // write-only strobes
            `EE_REG_STATUS: apb_rsp.prdata = status;
            default:        hit = 1'b0;
        endcase
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = access && (!hit || (cmd_wr && busy_q));
    end

    always_ff @(posedge CLK)
    begin
        if (wr_acc && apb_req.paddr == `EE_REG_ADDR)
            addr_q <= ee_addr_t'(apb_req.pwdata);
        if (wr_acc && apb_req.paddr == `EE_REG_WDATA)
            wdata_q <= ee_byte_t'(apb_req.pwdata);
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy_q      <= 1'b0;
            done_q      <= 1'b0;
            nack_q      <= 1'b0;
            rdata_q     <= '0;
            cmd_valid_q <= 1'b0;
            cmd_read_q  <= 1'b0;
        end
        else
        begin
            cmd_valid_q <= cmd_ok;
            if (cmd_ok)
            begin
                busy_q     <= 1'b1;
                done_q     <= 1'b0;
                cmd_read_q <= apb_req.pwdata[1];   // read wins over write
            end
            else if (rsp.done)
            begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
                nack_q <= rsp.nack;
                if (cmd_read_q)
                    rdata_q <= rsp.rdata;
            end
        end
    end

    always_comb
    begin
        cmd.valid   = cmd_valid_q;
        cmd.is_read = cmd_read_q;
        cmd.addr    = addr_q;
        cmd.wdata   = wdata_q;
    end

endmodule

/* design/eeprom_wr.sv */
`timescale 1ns/1ns
`include "eeprom_defines.svh"

module eeprom_wr
    import eeprom_types_pkg::*;
    import eeprom_bus_pkg::*;
(
    input  logic     CLK,
    input  logic     RESET,
    input  ee_cmd_t  cmd,
    output ee_rsp_t  rsp,
    output bit_req_t bit_req,
    input  bit_rsp_t bit_rsp
);

    typedef enum logic [3:0] {
        S_IDLE,
        S_START,
        S_CTRL_W,   // control byte, write bit
        S_ADDR,
        S_DATA,
        S_RESTART,
        S_CTRL_R,   // control byte, read bit
        S_READ,
        S_STOP
    } seq_state_e;

    seq_state_e state;
    seq_state_e state_nx;
    ee_addr_t   addr_q;
    ee_byte_t   wdata_q;
    ee_byte_t   rdata_q;
    logic       read_q;
    logic       issue_q;
    logic       nack_q;
    logic       done_q;
    logic       ack_fail;

    // only a byte write returns a real acknowledge
    assign ack_fail = (bit_req.op == OP_WRITE) && !bit_rsp.ack_ok;

    always_comb
    begin
        bit_req.valid = issue_q;
        bit_req.op    = OP_WRITE;
        bit_req.tx    = '0;
        case (state)
            S_START:   bit_req.op = OP_START;
            S_RESTART: bit_req.op = OP_RESTART;
            S_READ:    bit_req.op = OP_READ;
            S_STOP:    bit_req.op = OP_STOP;
            S_IDLE:    bit_req.op = OP_STOP;
            S_CTRL_W:  bit_req.tx = {`EE_DEV_CODE, addr_q[10:8], 1'b0};
            S_CTRL_R:  bit_req.tx = {`EE_DEV_CODE, addr_q[10:8], 1'b1};
            S_ADDR:    bit_req.tx = addr_q[7:0];
            S_DATA:    bit_req.tx = wdata_q;
            default:   bit_req.tx = '0;
        endcase
    end

    always_comb
    begin
        case (state)
            S_START:   state_nx = S_CTRL_W;
            S_CTRL_W:  state_nx = ack_fail ? S_STOP : S_ADDR;
            S_ADDR:
            begin
                if (ack_fail)
                    state_nx = S_STOP;
                else if (read_q)
                    state_nx = S_RESTART;   // dummy write done, turn around
                else
                    state_nx = S_DATA;
            end
            S_DATA:    state_nx = S_STOP;
            S_RESTART: state_nx = S_CTRL_R;
            S_CTRL_R:  state_nx = ack_fail ? S_STOP : S_READ;
            S_READ:    state_nx = S_STOP;
            default:   state_nx = S_IDLE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= S_IDLE;
            issue_q <= 1'b0;
            nack_q  <= 1'b0;
            done_q  <= 1'b0;
            rdata_q <= '0;
        end
        else
        begin
            done_q <= 1'b0;
            if (state == S_IDLE)
            begin
                if (cmd.valid)
                begin
                    state   <= S_START;
                    issue_q <= 1'b1;
                    nack_q  <= 1'b0;
                end
            end
            else if (issue_q && bit_rsp.done)
            begin
                issue_q <= 1'b0;   // one idle cycle before the next op
                state   <= state_nx;
                if (ack_fail)
                    nack_q <= 1'b1;
                if (state == S_READ)
                    rdata_q <= bit_rsp.rx;
                if (state == S_STOP)
                    done_q <= 1'b1;
            end
            else if (!issue_q)
            begin
                issue_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == S_IDLE && cmd.valid)
        begin
            addr_q  <= cmd.addr;
            wdata_q <= cmd.wdata;
            read_q  <= cmd.is_read;
        end
    end

    assign rsp = '{done: done_q, nack: nack_q, rdata: rdata_q};

endmodule

/* design/twi_bit_engine.sv */
`timescale 1ns/1ns
`include "eeprom_defines.svh"

module twi_bit_engine
    import eeprom_types_pkg::*;
    import eeprom_bus_pkg::*;
(
    input  logic     CLK,
    input  logic     RESET,
    input  bit_req_t req,
    output bit_rsp_t rsp,
    output logic     scl,
    output logic     sda_oe,
    input  logic     sda_in
);

    localparam int QTR = `EE_SCL_QTR;
    localparam int QW  = $clog2(QTR + 1);
    localparam logic [QW-1:0] Q_LAST = QW'(QTR - 1);

    typedef enum logic [1:0] {
        E_IDLE,
        E_COND,   // start, restart or stop, one bit time
        E_BYTE    // eight data bits plus ack
    } eng_state_e;

    eng_state_e    state;
    bit_op_e       op_q;
    logic [QW-1:0] qcnt;
    logic [1:0]    phase;   // 0 low, 1-2 high, 3 low
    logic [3:0]    bit_cnt;
    ee_byte_t      sh;
    logic          ack_q;
    logic          done_q;
    logic          q_end;
    logic          sample;
    logic          bit_end;
    logic          start_op;
    logic          scl_d;
    logic          oe_d;

    assign q_end    = (qcnt == Q_LAST);
    assign sample   = q_end && (phase == 2'd2);   // late in the high half
    assign bit_end  = q_end && (phase == 2'd3);
    assign start_op = (state == E_IDLE) && req.valid && !done_q;

    always_comb
    begin
        scl_d = scl;   // idle holds the line where the last op left it
        oe_d  = sda_oe;
        if (state != E_IDLE)
        begin
            scl_d = (phase == 2'd1) || (phase == 2'd2)
                 || (phase == 2'd0 && op_q == OP_START)
                 || (phase == 2'd3 && op_q == OP_STOP);
            case (op_q)
                OP_START, OP_RESTART: oe_d = phase[1];    // sda falls, scl high
                OP_STOP:              oe_d = !phase[1];   // sda rises, scl high
                OP_WRITE:             oe_d = (bit_cnt != 4'd8) && !sh[7];
                default:              oe_d = 1'b0;        // read and nack bit
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= E_IDLE;
            done_q  <= 1'b0;
            qcnt    <= '0;
            phase   <= '0;
            bit_cnt <= '0;
            scl     <= 1'b1;
            sda_oe  <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            scl    <= scl_d;
            sda_oe <= oe_d;
            if (start_op)
            begin
                qcnt    <= '0;
                phase   <= '0;
                bit_cnt <= '0;
                state   <= (req.op == OP_WRITE || req.op == OP_READ) ? E_BYTE : E_COND;
            end
            else if (state != E_IDLE)
            begin
                qcnt <= q_end ? '0 : qcnt + 1'b1;
                if (q_end)
                    phase <= phase + 1'b1;
                if (bit_end)
                begin
                    if (state == E_COND || bit_cnt == 4'd8)
                    begin
                        state  <= E_IDLE;
                        done_q <= 1'b1;
                    end
                    else
                    begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (start_op)
        begin
            op_q <= req.op;
            sh   <= req.tx;
        end
        else if (state == E_BYTE && bit_cnt != 4'd8)
        begin
            if (op_q == OP_READ && sample)
                sh <= {sh[6:0], sda_in};   // msb first
            if (op_q == OP_WRITE && bit_end)
                sh <= {sh[6:0], 1'b0};
        end
        if (state == E_BYTE && bit_cnt == 4'd8 && sample)
            ack_q <= !sda_in;   // slave pulls low
    end

    assign rsp = '{done: done_q, ack_ok: ack_q, rx: sh};

endmodule

/* design/eeprom_ctrl_top.sv */
`timescale 1ns/1ns

module eeprom_ctrl_top
    import eeprom_bus_pkg::*;
(
    input  logic     CLK,
    input  logic     RESET,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp,
    output logic     scl,
    output logic     sda_oe,
    input  logic     sda_in
);

    ee_cmd_t  cmd;
    ee_rsp_t  rsp;
    bit_req_t bit_req;
    bit_rsp_t bit_rsp;

    eeprom_apb_regs eeprom_apb_regs_inst (
        .CLK     (CLK),
        .RESET   (RESET),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .cmd     (cmd),
        .rsp     (rsp)
    );

    eeprom_wr eeprom_wr_inst (
        .CLK     (CLK),
        .RESET   (RESET),
        .cmd     (cmd),
        .rsp     (rsp),
        .bit_req (bit_req),
        .bit_rsp (bit_rsp)
    );

    // open-drain pins, resolved outside
    twi_bit_engine twi_bit_engine_inst (
        .CLK    (CLK),
        .RESET  (RESET),
        .req    (bit_req),
        .rsp    (bit_rsp),
        .scl    (scl),
        .sda_oe (sda_oe),
        .sda_in (sda_in)
    );

endmodule

/* test/eeprom_model.sv */
`timescale 1ns/1ns
`include "eeprom_defines.svh"

module eeprom_model
    import eeprom_types_pkg::*;
(
    input  logic scl,
    input  logic sda,
    input  logic wp,
    output logic sda_oe
);

    // about 16 bit times at a 4 ns clock
    localparam int STALL_NS = 16 * 4 * `EE_SCL_QTR * 4;

    typedef enum logic [2:0] {
        M_IDLE,
        M_CTRL,
        M_ADDR,
        M_WDATA,
        M_RDATA,
        M_IGNORE   // not addressed or nacked, wait for start or stop
    } mdl_state_e;

    ee_byte_t   mem [0:`EE_MEM_BYTES-1];
    mdl_state_e state;
    mdl_state_e state_nx;
    ee_addr_t   ptr;
    ee_byte_t   sh;
    ee_byte_t   rd_byte;
    int         cnt;        // scl falls inside the current byte
    logic       skip_fall;
    logic       mst_ack;
    time        last_edge;

    initial
    begin
        for (int a = 0; a < `EE_MEM_BYTES; a++)
            mem[a] = ee_byte_t'(a) ^ {a[10:8], 5'b0} ^ 8'h5A;
        state     = M_IDLE;
        state_nx  = M_IDLE;
        sda_oe    = 1'b0;
        cnt       = 0;
        skip_fall = 1'b0;
        ptr       = '0;
        last_edge = 0;
    end

    // received byte complete, decide on the acknowledge
    task automatic take_byte();
        logic ack;
        ack = 1'b1;
        case (state)
            M_CTRL:
            begin
                if (sh[7:4] == `EE_DEV_CODE)
                begin
                    ptr[10:8] = sh[3:1];
                    state_nx  = sh[0] ? M_RDATA : M_ADDR;
                end
                else
                begin
                    ack      = 1'b0;
                    state_nx = M_IGNORE;
                end
            end
            M_ADDR:
            begin
                ptr[7:0] = sh;
                state_nx = M_WDATA;
            end
            default:
            begin
                if (wp)
                begin
                    ack      = 1'b0;   // protected, array untouched
                    state_nx = M_IGNORE;
                end
                else
                begin
                    mem[ptr] = sh;
                    ptr      = ptr + 1'b1;
                    state_nx = M_WDATA;
                end
            end
        endcase
        sda_oe = ack;
    endtask

    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            state     = M_CTRL;
            state_nx  = M_CTRL;
            cnt       = 0;
            skip_fall = 1'b1;   // scl still has to fall after the start
            sda_oe    = 1'b0;
        end
    end

    always @(posedge sda)
    begin
        if (scl === 1'b1)
        begin
            state  = M_IDLE;   // stop
            sda_oe = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        last_edge = $time;
        if (state == M_RDATA && cnt == 8)
            mst_ack = !sda;
        else if ((state == M_CTRL || state == M_ADDR || state == M_WDATA) && cnt < 8)
            sh = {sh[6:0], sda};
    end

    always @(negedge scl)
    begin
        last_edge = $time;
        if (skip_fall)
            skip_fall = 1'b0;
        else if (state != M_IDLE && state != M_IGNORE)
        begin
            cnt = cnt + 1;
            if (cnt == 8 && state != M_RDATA)
                take_byte();
            else if (cnt == 9)
            begin
                cnt    = 0;
                sda_oe = 1'b0;
                if (state == M_RDATA)
                    state_nx = mst_ack ? M_RDATA : M_IGNORE;
                state = state_nx;
                if (state == M_RDATA)
                begin
                    rd_byte = mem[ptr];
                    ptr     = ptr + 1'b1;
                    sda_oe  = !rd_byte[7];
                end
            end
            else if (state == M_RDATA)
                sda_oe = (cnt < 8) ? !rd_byte[7 - cnt] : 1'b0;   // bit 8 is the master's
        end
    end

    always
    begin
        #(STALL_NS);
        if (state != M_IDLE && ($time - last_edge) > STALL_NS)
        begin
            $display("eeprom model: scl stalled mid transfer, slave released SDA");
            state  = M_IDLE;
            sda_oe = 1'b0;
        end
    end

endmodule

/* test/eeprom_ctrl_tb.sv */
`timescale 1ns/1ns
`include "eeprom_defines.svh"

module eeprom_ctrl_tb
    import eeprom_types_pkg::*;
    import eeprom_bus_pkg::*;
();

    localparam logic [1:0] T_WRITE  = 2'd0;
    localparam logic [1:0] T_READ   = 2'd1;
    localparam logic [1:0] T_BUSY   = 2'd2;   // write plus a refused command
    localparam logic [1:0] T_BADREG = 2'd3;
    localparam int N_FIXED    = 20;
    localparam int N_RAND     = 3;
    localparam int N_STEPS    = N_FIXED + 2 * N_RAND;
    localparam int POLL_LIMIT = 1000;

    typedef struct packed {
        logic [1:0] kind;
        ee_addr_t   addr;
        ee_byte_t   data;
        logic       wp;
        logic       nack;
    } step_t;

    logic     CLK;
    logic     RESET;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    logic     scl;
    logic     dut_sda_oe;
    logic     mdl_sda_oe;
    logic     sda;
    logic     wp;
    integer   seed;
    int       errors;
    int       timeouts;
    ee_byte_t shadow [0:`EE_MEM_BYTES-1];
    step_t    steps [0:N_STEPS-1];

    eeprom_ctrl_top eeprom_ctrl_top_inst (
        .CLK     (CLK),
        .RESET   (RESET),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .scl     (scl),
        .sda_oe  (dut_sda_oe),
        .sda_in  (sda)
    );

    eeprom_model eeprom_model_inst (
        .scl    (scl),
        .sda    (sda),
        .wp     (wp),
        .sda_oe (mdl_sda_oe)
    );

    assign sda = !(dut_sda_oe || mdl_sda_oe);   // pull-up wired-AND

    initial
    begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    function automatic ee_byte_t powerup_byte(input ee_addr_t a);
        return a[7:0] ^ {a[10:8], 5'b0} ^ 8'h5A;
    endfunction

    task automatic check_equal(input apb_word_t actual, input apb_word_t expected,
                               input string what);
        if (actual !== expected)
        begin
            errors++;
            $display("FAILED at %0t ns: %s, got %0h, expected %0h", $time, what, actual,
                     expected);
        end
    endtask

    task automatic apb_access(input logic is_write, input apb_addr_t addr,
                              input apb_word_t wdata, output apb_word_t rdata,
                              output logic err);
        @(posedge CLK);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= is_write;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= wdata;
        @(posedge CLK);
        apb_req.penable <= 1'b1;
        @(negedge CLK);   // mid access phase
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        check_equal(apb_rsp.pready, 1'b1, "pready in access phase");
        @(posedge CLK);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_word_t data);
        apb_word_t rd;
        logic      err;
        apb_access(1'b1, addr, data, rd, err);
        check_equal(err, 1'b0, $sformatf("pslverr on write to %0h", addr));
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_word_t data);
        logic err;
        apb_access(1'b0, addr, '0, data, err);
        check_equal(err, 1'b0, $sformatf("pslverr on read of %0h", addr));
    endtask

    task automatic wait_idle(output apb_word_t status);
        int polls;
        polls = 0;
        apb_read(`EE_REG_STATUS, status);
        while (status[0] && polls < POLL_LIMIT)
        begin
            apb_read(`EE_REG_STATUS, status);
            polls++;
        end
        if (status[0])
        begin
            timeouts++;
            $display("timeout at %0t ns: controller still busy after %0d polls", $time, polls);
        end
        else
        begin
            check_equal(status[1], 1'b1, "done flag after transaction");
            @(negedge CLK);
            check_equal(scl, 1'b1, "scl idle after transaction");
            check_equal(sda, 1'b1, "sda released after stop");
        end
    endtask

    task automatic fill_table();
        int       k;
        ee_addr_t r_addr;
        ee_byte_t r_data;
        steps[0]  = {T_WRITE,  11'h000, 8'hA5, 1'b0, 1'b0};
        steps[1]  = {T_READ,   11'h000, 8'h00, 1'b0, 1'b0};
        steps[2]  = {T_WRITE,  11'h1FF, 8'h3C, 1'b0, 1'b0};
        steps[3]  = {T_READ,   11'h1FF, 8'h00, 1'b0, 1'b0};
        steps[4]  = {T_WRITE,  11'h2AA, 8'h96, 1'b0, 1'b0};
        steps[5]  = {T_READ,   11'h2AA, 8'h00, 1'b0, 1'b0};
        steps[6]  = {T_WRITE,  11'h7F1, 8'h0F, 1'b0, 1'b0};
        steps[7]  = {T_READ,   11'h7F1, 8'h00, 1'b0, 1'b0};
        steps[8]  = {T_WRITE,  11'h455, 8'hC3, 1'b0, 1'b0};
        steps[9]  = {T_READ,   11'h455, 8'h00, 1'b0, 1'b0};
        steps[10] = {T_READ,   11'h333, 8'h00, 1'b0, 1'b0};   // never written
        steps[11] = {T_READ,   11'h6C2, 8'h00, 1'b0, 1'b0};
        steps[12] = {T_WRITE,  11'h123, 8'hE1, 1'b1, 1'b1};
        steps[13] = {T_READ,   11'h123, 8'h00, 1'b0, 1'b0};
        steps[14] = {T_WRITE,  11'h000, 8'h11, 1'b1, 1'b1};
        steps[15] = {T_READ,   11'h000, 8'h00, 1'b0, 1'b0};
        steps[16] = {T_BUSY,   11'h5AB, 8'h44, 1'b0, 1'b0};
        steps[17] = {T_READ,   11'h5AB, 8'h00, 1'b0, 1'b0};
        steps[18] = {T_BADREG, 11'h001, 8'h00, 1'b0, 1'b0};   // addr holds the offset
        steps[19] = {T_BADREG, 11'h00F, 8'h00, 1'b0, 1'b0};
        for (k = 0; k < N_RAND; k++)
        begin
            r_addr = ee_addr_t'($random(seed));
            r_data = ee_byte_t'($random(seed));
            steps[N_FIXED + 2 * k]     = {T_WRITE, r_addr, r_data, 1'b0, 1'b0};
            steps[N_FIXED + 2 * k + 1] = {T_READ,  r_addr, 8'h00,  1'b0, 1'b0};
        end
    endtask

    task automatic run_step(input step_t s, input int idx);
        apb_word_t status;
        apb_word_t rd;
        logic      err;
        case (s.kind)
            T_WRITE, T_BUSY:
            begin
                @(posedge CLK);
                wp <= s.wp;
                apb_write(`EE_REG_ADDR, apb_word_t'(s.addr));
                apb_write(`EE_REG_WDATA, apb_word_t'(s.data));
                apb_write(`EE_REG_CMD, 32'h1);
                if (s.kind == T_BUSY)
                begin
                    apb_access(1'b1, `EE_REG_CMD, 32'h2, rd, err);
                    check_equal(err, 1'b1, $sformatf("step %0d pslverr on busy CMD", idx));
                end
                wait_idle(status);
                check_equal(status[2], s.nack, $sformatf("step %0d write nack", idx));
                if (!s.wp)
                    shadow[s.addr] = s.data;
            end
            T_READ:
            begin
                apb_write(`EE_REG_ADDR, apb_word_t'(s.addr));
                apb_write(`EE_REG_CMD, 32'h2);
                wait_idle(status);
                check_equal(status[2], 1'b0, $sformatf("step %0d read nack", idx));
                check_equal(status[`EE_RDATA_OFS +: 8], shadow[s.addr],
                            $sformatf("step %0d read data at %0h", idx, s.addr));
            end
            default:
            begin
                apb_access(1'b1, apb_addr_t'(s.addr), 32'hFFFF, rd, err);
                check_equal(err, 1'b1, $sformatf("step %0d pslverr on bad write", idx));
                apb_access(1'b0, apb_addr_t'(s.addr), '0, rd, err);
                check_equal(err, 1'b1, $sformatf("step %0d pslverr on bad read", idx));
            end
        endcase
    endtask

    initial
    begin
        apb_word_t rd;
        RESET    = 1'b1;
        apb_req  = '0;
        wp       = 1'b0;
        seed     = 32'h58ea;
        errors   = 0;
        timeouts = 0;
        for (int a = 0; a < `EE_MEM_BYTES; a++)
            shadow[a] = powerup_byte(ee_addr_t'(a));
        fill_table();
        repeat (16) @(posedge CLK);
        RESET <= 1'b0;
        @(negedge CLK);
        check_equal(scl, 1'b1, "scl after reset");
        check_equal(dut_sda_oe, 1'b0, "sda_oe after reset");
        apb_read(`EE_REG_STATUS, rd);
        check_equal(rd, '0, "status after reset");
        for (int i = 0; i < N_STEPS; i++)
            run_step(steps[i], i);
        $display("mismatches: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

/* tb.f */
+incdir+design
design/eeprom_types_pkg.sv
design/eeprom_bus_pkg.sv
design/eeprom_apb_regs.sv
design/eeprom_wr.sv
design/twi_bit_engine.sv
design/eeprom_ctrl_top.sv
test/eeprom_model.sv
test/eeprom_ctrl_tb.sv

/* Bender.yml */
package:
  name: eeprom_ctrl

sources:
  - include_dirs:
      - design
    files:
      - design/eeprom_types_pkg.sv
      - design/eeprom_bus_pkg.sv
      - design/eeprom_apb_regs.sv
      - design/eeprom_wr.sv
      - design/twi_bit_engine.sv
      - design/eeprom_ctrl_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/eeprom_model.sv
      - test/eeprom_ctrl_tb.sv
